// ==== sources.f ====
verilog/ilk_mgmt_pkg.sv
verilog/ilk_status_sync.sv
verilog/ilk_lane_csr.sv
verilog/ilk_phy_csr.sv
verilog/ilk_mgmt_readout.sv
verilog/ilk_mgmt_top.sv
dv/ilk_mgmt_checker.sv
dv/ilk_mgmt_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the Interlaken management testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f sources.f --top-module ilk_mgmt_tb -o ilk_mgmt_sim \
   && ./obj_dir/ilk_mgmt_sim | tee sim.log \
   || { echo "build or run failed"; exit 1; }

grep -q '^STATUS: PASS$' sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// ==== dv/ilk_mgmt_tb.sv ====
//####################
// Interlaken management testbench
// clock, reset, DUT and random bus/status stimulus
//####################
`timescale 1ns/1ns

module ilk_mgmt_tb
   import ilk_mgmt_pkg::*;
();

   localparam int N_CTRL   = 24;   // control write/read pairs
   localparam int N_LOCK   = 8;
   localparam int N_ROUNDS = 2;    // lane select sweeps
   localparam int N_UNMAP  = 20;
   localparam int SETTLE   = SYNC_DEPTH + 2;

   // bus accesses, status settles and test ends, 4 cycles each at most
   localparam int NUM_OPS = 5 + 2*N_CTRL + 2*N_LOCK + N_ROUNDS*(1 + 3*8) + 3*N_UNMAP + 1 + 5;
   localparam int CYCLE_LIMIT = NUM_OPS*4 + 200;

   localparam logic [MGMT_ADDR_W-1:0] A_LOCK      = {1'b0, PMA_LOCK_STATUS};
   localparam logic [MGMT_ADDR_W-1:0] A_RST       = {1'b0, PMA_RESET_CTRL};
   localparam logic [MGMT_ADDR_W-1:0] A_LOOP      = {1'b0, PMA_LOOPBACK};
   localparam logic [MGMT_ADDR_W-1:0] A_LANE_SEL  = {1'b1, PCS_PAGE, PCS_LANE_SEL};
   localparam logic [MGMT_ADDR_W-1:0] A_LANE_STAT = {1'b1, PCS_PAGE, PCS_LANE_STATUS};

   logic                                   mgmt_clk;
   logic                                   rst_n;
   logic                                   mgmt_write;
   logic                                   mgmt_read;
   mgmt_addr_t                             mgmt_address;
   logic [MGMT_DATA_W-1:0]                 mgmt_writedata;
   logic [MGMT_DATA_W-1:0]                 mgmt_readdata;
   logic                                   mgmt_waitrequest;
   logic                                   pll_locked;
   logic [LANE_COUNT-1:0]                  rx_lockedtodata;
   logic [LANE_COUNT-1:0]                  rx_lockedtoref;
   logic [LANE_COUNT-1:0][LANE_STAT_W-1:0] rx_lane_status;
   logic                                   tx_reset_req;
   logic                                   rx_reset_req;
   logic [LANE_COUNT-1:0]                  serial_loopback;
   int                                     test_num;
   logic                                   test_end;
   int                                     error_count;
   int                                     check_count;
   logic                                   timed_out;

   ilk_mgmt_top dut (.*);

   ilk_mgmt_checker u_checker (.*, .cycle_limit(CYCLE_LIMIT));

   initial begin
      mgmt_clk = 1'b0;
      forever #10 mgmt_clk = ~mgmt_clk;
   end

   //####################
   // bus operations, all start 2 ns after an edge
   //####################
   task automatic write_reg(input logic [MGMT_ADDR_W-1:0] addr, input logic [MGMT_DATA_W-1:0] data);
      mgmt_read      = 1'b0;
      mgmt_write     = 1'b1;
      mgmt_address   = addr;
      mgmt_writedata = data;
      @(posedge mgmt_clk);
      #2;
      mgmt_write = 1'b0;
   endtask

   // read stays high afterwards so the next read follows back to back
   task automatic read_reg(input logic [MGMT_ADDR_W-1:0] addr);
      mgmt_write   = 1'b0;
      mgmt_read    = 1'b1;
      mgmt_address = addr;
      @(posedge mgmt_clk);
      while (mgmt_waitrequest) @(posedge mgmt_clk);
      #2;
   endtask

   task automatic idle(input int n);
      mgmt_read  = 1'b0;
      mgmt_write = 1'b0;
      repeat (n) @(posedge mgmt_clk);
      #2;
   endtask

   task automatic randomize_status();
      logic [31:0] r;
      r               = $urandom();
      pll_locked      = r[0];
      rx_lockedtodata = r[4 +: LANE_COUNT];
      rx_lockedtoref  = r[8 +: LANE_COUNT];
      for (int i = 0; i < LANE_COUNT; i++) begin
         rx_lane_status[i] = LANE_STAT_W'($urandom());
      end
      idle(SETTLE);   // let the synchronizers catch up
   endtask

   task automatic finish_test();
      idle(0);
      test_end = 1'b1;
      @(posedge mgmt_clk);
      #2;
      test_end = 1'b0;
   endtask

   // PMA offsets 3..127, PCS pages 1..31, or PCS regs 2 and 3
   function automatic logic [MGMT_ADDR_W-1:0] unmapped_addr();
      logic [31:0] r;
      r = $urandom();
      case (r[31:30])
         2'd0:    return {1'b0, 7'(3 + r[6:0] % 125)};
         2'd1:    return {1'b1, 5'(1 + r[4:0] % 31), r[6:5]};
         default: return {1'b1, 5'b0, 1'b1, r[0]};
      endcase
   endfunction

   //####################
   // tests
   //####################
   initial begin
      logic [MGMT_DATA_W-1:0] r;
      logic [MGMT_ADDR_W-1:0] a;
      void'($urandom(32'hf59b_86be));
      rst_n           = 1'b0;
      mgmt_write      = 1'b0;
      mgmt_read       = 1'b0;
      mgmt_address    = '0;
      mgmt_writedata  = '0;
      pll_locked      = 1'b0;
      rx_lockedtodata = '0;
      rx_lockedtoref  = '0;
      rx_lane_status  = '0;
      test_num        = 0;
      test_end        = 1'b0;
      repeat (4) @(posedge mgmt_clk);
      #2;
      rst_n = 1'b1;

      test_num = 1;   // reset values
      randomize_status();
      read_reg(A_LOCK);
      read_reg(A_RST);
      read_reg(A_LOOP);
      read_reg(A_LANE_SEL);
      finish_test();

      test_num = 2;   // control registers
      for (int i = 0; i < N_CTRL; i++) begin
         r = $urandom();
         a = r[31] ? A_RST : A_LOOP;
         write_reg(a, $urandom());
         read_reg(a);
      end
      finish_test();

      test_num = 3;   // lock status word
      for (int i = 0; i < N_LOCK; i++) begin
         randomize_status();
         read_reg(A_LOCK);
      end
      finish_test();

      test_num = 4;   // indirect lane status
      for (int k = 0; k < N_ROUNDS; k++) begin
         randomize_status();
         for (int sel = 0; sel < 8; sel++) begin
            r = $urandom();
            r[LANE_SEL_W-1:0] = LANE_SEL_W'(sel);
            write_reg(A_LANE_SEL, r);
            read_reg(A_LANE_SEL);
            read_reg(A_LANE_STAT);
         end
      end
      finish_test();

      test_num = 5;   // unmapped space and bus timing
      for (int i = 0; i < N_UNMAP; i++) begin
         a = unmapped_addr();
         write_reg(a, $urandom());
         read_reg(a);
         r = $urandom();
         case (r[1:0])
            2'd0:    read_reg(A_RST);
            2'd1:    read_reg(A_LOOP);
            2'd2:    read_reg(A_LANE_SEL);
            default: read_reg(A_LOCK);
         endcase
      end
      idle(4);
      finish_test();

      $display("tests 5, checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   initial begin
      wait (timed_out);
      $display("run stopped at the cycle limit of %0d before the tests finished", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== dv/ilk_mgmt_checker.sv ====
//####################
// Management bus checker
// register model from observed writes, read data and
// waitrequest checks, control port checks, per-test lines
//####################
`timescale 1ns/1ns

module ilk_mgmt_checker
   import ilk_mgmt_pkg::*;
(
   input  logic                                   mgmt_clk,
   input  logic                                   rst_n,
   input  logic                                   mgmt_write,
   input  logic                                   mgmt_read,
   input  logic [MGMT_ADDR_W-1:0]                 mgmt_address,
   input  logic [MGMT_DATA_W-1:0]                 mgmt_writedata,
   input  logic [MGMT_DATA_W-1:0]                 mgmt_readdata,
   input  logic                                   mgmt_waitrequest,
   input  logic                                   pll_locked,
   input  logic [LANE_COUNT-1:0]                  rx_lockedtodata,
   input  logic [LANE_COUNT-1:0]                  rx_lockedtoref,
   input  logic [LANE_COUNT-1:0][LANE_STAT_W-1:0] rx_lane_status,
   input  logic                                   tx_reset_req,
   input  logic                                   rx_reset_req,
   input  logic [LANE_COUNT-1:0]                  serial_loopback,
   input  int                                     test_num,
   input  logic                                   test_end,
   input  int                                     cycle_limit,
   output int                                     error_count,
   output int                                     check_count,
   output logic                                   timed_out
);

   logic [1:0]                            m_rst;      // bit 0 tx, bit 1 rx
   logic [LANE_COUNT-1:0]                 m_loop;
   logic [LANE_SEL_W-1:0]                 m_sel;
   int                                    read_cycles;  // cycles the read strobe has been held
   logic                                  exp_wait;
   logic [LANE_COUNT*(LANE_STAT_W+2):0]   stat_now;
   logic [LANE_COUNT*(LANE_STAT_W+2):0]   stat_last;
   int                                    stat_age;   // cycles since status moved
   int                                    cycles = 0;
   int                                    test_errs = 0;
   int                                    test_checks = 0;

   assign stat_now = {pll_locked, rx_lockedtodata, rx_lockedtoref, rx_lane_status};

   initial begin
      error_count = 0;
      check_count = 0;
      timed_out   = 1'b0;
   end

   function automatic logic [MGMT_DATA_W-1:0] expected_read(input logic [MGMT_ADDR_W-1:0] addr);
      logic [MGMT_DATA_W-1:0] word;
      int                     lane;
      word = '0;
      lane = int'(m_sel);
      if (!addr[7]) begin
         case (addr[6:0])
            PMA_LOCK_STATUS: begin
               word[0]              = pll_locked;
               word[4 +: LANE_COUNT] = rx_lockedtodata;
               word[8 +: LANE_COUNT] = rx_lockedtoref;
            end
            PMA_RESET_CTRL: word[1:0] = m_rst;
            PMA_LOOPBACK:   word[LANE_COUNT-1:0] = m_loop;
            default:        word = '0;
         endcase
      end else if (addr[6:2] == PCS_PAGE && addr[1:0] == PCS_LANE_SEL) begin
         word[LANE_SEL_W-1:0] = m_sel;
      end else if (addr[6:2] == PCS_PAGE && addr[1:0] == PCS_LANE_STATUS && lane < LANE_COUNT) begin
         word[ST_ALIGN_VAL]      = rx_lane_status[lane][0];
         word[ST_FRAME_LOCK]     = rx_lane_status[lane][1];
         word[ST_FRAMING_ERR]    = rx_lane_status[lane][2];
         word[ST_CRC32_ERR]      = rx_lane_status[lane][3];
         word[ST_SCRAM_MISMATCH] = rx_lane_status[lane][4];
         word[ST_MISSING_SYNC]   = rx_lane_status[lane][5];
      end
      return word;
   endfunction

   task automatic report_error(input string msg);
      error_count++;
      test_errs++;
      $display("%s at %0t ns", msg, $time);
   endtask

   task automatic check_value(input string name, input logic [MGMT_DATA_W-1:0] got,
                              input logic [MGMT_DATA_W-1:0] exp);
      check_count++;
      test_checks++;
      if (got !== exp) begin
         report_error($sformatf("Fail %s got 0x%08h expected 0x%08h", name, got, exp));
      end
   endtask

   task automatic model_write(input logic [MGMT_ADDR_W-1:0] addr,
                              input logic [MGMT_DATA_W-1:0] data);
      if (!addr[7]) begin
         if (addr[6:0] == PMA_RESET_CTRL) m_rst = data[1:0];
         else if (addr[6:0] == PMA_LOOPBACK) m_loop = data[LANE_COUNT-1:0];
      end else if (addr[6:2] == PCS_PAGE && addr[1:0] == PCS_LANE_SEL) begin
         m_sel = data[LANE_SEL_W-1:0];
      end
   endtask

   //####################
   // per-cycle checks
   //####################
   always @(posedge mgmt_clk) begin
      cycles = cycles + 1;
      if (cycles >= cycle_limit) timed_out = 1'b1;
      if (!rst_n) begin
         m_rst       = '0;
         m_loop      = '0;
         m_sel       = '0;
         read_cycles = 0;
         stat_age    = 0;
      end else begin
         if (stat_now != stat_last) stat_age = 0;
         else if (stat_age < 100) stat_age = stat_age + 1;
         check_value("tx_reset_req", 32'(tx_reset_req), 32'(m_rst[0]));
         check_value("rx_reset_req", 32'(rx_reset_req), 32'(m_rst[1]));
         check_value("serial_loopback", 32'(serial_loopback), 32'(m_loop));
         // stall in the first cycle of a read only, reads are two cycles each
         exp_wait = mgmt_read && (read_cycles % 2 == 0);
         check_value("mgmt_waitrequest", 32'(mgmt_waitrequest), 32'(exp_wait));
         if (mgmt_read && !exp_wait) begin
            if (stat_age <= SYNC_DEPTH) begin
               report_error("read finished before the status inputs settled");
            end
            check_value($sformatf("mgmt_readdata @0x%02h", mgmt_address), mgmt_readdata,
                        expected_read(mgmt_address));
         end
         read_cycles = mgmt_read ? read_cycles + 1 : 0;
         if (mgmt_write) model_write(mgmt_address, mgmt_writedata);   // takes effect next cycle
         if (test_end) begin
            $display("test %0d done: %0d checks, %0d errors", test_num, test_checks, test_errs);
            test_checks = 0;
            test_errs   = 0;
         end
      end
      stat_last = stat_now;
   end

endmodule

// ==== verilog/ilk_mgmt_top.sv ====
//####################
// Interlaken PHY management top
// status synchronizers, PCS lane registers, PMA registers
// and the read path on one management bus
//####################
`timescale 1ns/1ns

module ilk_mgmt_top
   import ilk_mgmt_pkg::*;
(
   input  logic                                   mgmt_clk,
   input  logic                                   rst_n,
   input  logic                                   mgmt_write,
   input  logic                                   mgmt_read,
   input  mgmt_addr_t                             mgmt_address,
   input  logic [MGMT_DATA_W-1:0]                 mgmt_writedata,
   output logic [MGMT_DATA_W-1:0]                 mgmt_readdata,
   output logic                                   mgmt_waitrequest,
   input  logic                                   pll_locked,
   input  logic [LANE_COUNT-1:0]                  rx_lockedtodata,
   input  logic [LANE_COUNT-1:0]                  rx_lockedtoref,
   input  logic [LANE_COUNT-1:0][LANE_STAT_W-1:0] rx_lane_status,
   output logic                                   tx_reset_req,
   output logic                                   rx_reset_req,
   output logic [LANE_COUNT-1:0]                  serial_loopback
);

   logic                                   pll_locked_sync;
   logic [LANE_COUNT-1:0]                  rx_lockedtodata_sync;
   logic [LANE_COUNT-1:0]                  rx_lockedtoref_sync;
   logic [LANE_COUNT-1:0][LANE_STAT_W-1:0] rx_lane_status_sync;
   logic [MGMT_DATA_W-1:0]                 pma_readdata;
   logic [MGMT_DATA_W-1:0]                 pcs_readdata;

   ilk_status_sync u_sync (
      .mgmt_clk             (mgmt_clk),
      .rst_n                (rst_n),
      .pll_locked           (pll_locked),
      .rx_lockedtodata      (rx_lockedtodata),
      .rx_lockedtoref       (rx_lockedtoref),
      .rx_lane_status       (rx_lane_status),
      .pll_locked_sync      (pll_locked_sync),
      .rx_lockedtodata_sync (rx_lockedtodata_sync),
      .rx_lockedtoref_sync  (rx_lockedtoref_sync),
      .rx_lane_status_sync  (rx_lane_status_sync)
   );

   ilk_lane_csr u_lane_csr (
      .mgmt_clk            (mgmt_clk),
      .rst_n               (rst_n),
      .mgmt_write          (mgmt_write),
      .mgmt_address        (mgmt_address),
      .mgmt_writedata      (mgmt_writedata),
      .rx_lane_status_sync (rx_lane_status_sync),
      .pcs_readdata        (pcs_readdata)
   );

   ilk_phy_csr u_phy_csr (
      .mgmt_clk             (mgmt_clk),
      .rst_n                (rst_n),
      .mgmt_write           (mgmt_write),
      .mgmt_address         (mgmt_address),
      .mgmt_writedata       (mgmt_writedata),
      .pll_locked_sync      (pll_locked_sync),
      .rx_lockedtodata_sync (rx_lockedtodata_sync),
      .rx_lockedtoref_sync  (rx_lockedtoref_sync),
      .pma_readdata         (pma_readdata),
      .tx_reset_req         (tx_reset_req),
      .rx_reset_req         (rx_reset_req),
      .serial_loopback      (serial_loopback)
   );

   ilk_mgmt_readout u_readout (
      .mgmt_clk         (mgmt_clk),
      .rst_n            (rst_n),
      .mgmt_read        (mgmt_read),
      .mgmt_address     (mgmt_address),
      .pma_readdata     (pma_readdata),
      .pcs_readdata     (pcs_readdata),
      .mgmt_readdata    (mgmt_readdata),
      .mgmt_waitrequest (mgmt_waitrequest)
   );

endmodule

// ==== verilog/ilk_mgmt_readout.sv ====
//####################
// Management read path
// PMA/PCS data select, read data register and
// one cycle of waitrequest per read
//####################
`timescale 1ns/1ns

module ilk_mgmt_readout
   import ilk_mgmt_pkg::*;
(
   input  logic                   mgmt_clk,
   input  logic                   rst_n,
   input  logic                   mgmt_read,
   input  mgmt_addr_t             mgmt_address,
   input  logic [MGMT_DATA_W-1:0] pma_readdata,
   input  logic [MGMT_DATA_W-1:0] pcs_readdata,
   output logic [MGMT_DATA_W-1:0] mgmt_readdata,
   output logic                   mgmt_waitrequest
);

   logic                   read_phase;   // high in the second cycle of a read
   logic [MGMT_DATA_W-1:0] sel_data;

   assign sel_data = mgmt_address.pma.pcs_space ? pcs_readdata : pma_readdata;

   // first cycle of a read stalls while the data is captured
   assign mgmt_waitrequest = mgmt_read && !read_phase;

   always_ff @(posedge mgmt_clk) begin
      if (!rst_n) read_phase <= 1'b0;
      else        read_phase <= mgmt_waitrequest;
   end

   always_ff @(posedge mgmt_clk) begin
      if (!rst_n)                mgmt_readdata <= '0;
      else if (mgmt_waitrequest) mgmt_readdata <= sel_data;
   end

   // captured data belongs to the address still on the bus
   a_read_held: assert property (@(posedge mgmt_clk) disable iff (!rst_n)
      mgmt_waitrequest |=> mgmt_read && $stable(mgmt_address));

   // host holds the read, so the stall lasts exactly one cycle
   a_wait_one_cycle: assert property (@(posedge mgmt_clk) disable iff (!rst_n)
      mgmt_waitrequest |=> !mgmt_waitrequest);

endmodule

// ==== verilog/ilk_phy_csr.sv ====
//####################
// PMA control/status registers
// lock status readback, digital reset requests and
// per-lane serial loopback enables
//####################
`timescale 1ns/1ns

module ilk_phy_csr
   import ilk_mgmt_pkg::*;
(
   input  logic                   mgmt_clk,
   input  logic                   rst_n,
   input  logic                   mgmt_write,
   input  mgmt_addr_t             mgmt_address,
   input  logic [MGMT_DATA_W-1:0] mgmt_writedata,
   input  logic                   pll_locked_sync,
   input  logic [LANE_COUNT-1:0]  rx_lockedtodata_sync,
   input  logic [LANE_COUNT-1:0]  rx_lockedtoref_sync,
   output logic [MGMT_DATA_W-1:0] pma_readdata,
   output logic                   tx_reset_req,
   output logic                   rx_reset_req,
   output logic [LANE_COUNT-1:0]  serial_loopback
);

   logic                   pma_hit;
   logic [MGMT_DATA_W-1:0] lock_word;
   logic [MGMT_DATA_W-1:0] rst_word;
   logic [MGMT_DATA_W-1:0] loop_word;

   assign pma_hit = !mgmt_address.pma.pcs_space;

   //####################
   // control registers
   //####################
   always_ff @(posedge mgmt_clk) begin
      if (!rst_n) begin
         tx_reset_req    <= 1'b0;
         rx_reset_req    <= 1'b0;
         serial_loopback <= '0;
      end else if (mgmt_write && pma_hit) begin
         case (mgmt_address.pma.csr_index)
            PMA_RESET_CTRL: begin
               tx_reset_req <= mgmt_writedata[RST_TX_BIT];
               rx_reset_req <= mgmt_writedata[RST_RX_BIT];
            end
            PMA_LOOPBACK: serial_loopback <= mgmt_writedata[LANE_COUNT-1:0];
            default: ;   // lock status is read only, rest unmapped
         endcase
      end
   end

   //####################
   // read words
   //####################
   always_comb begin
      lock_word                                       = '0;
      lock_word[LOCK_PLL_BIT]                         = pll_locked_sync;
      lock_word[LOCK_DATA_LSB +: LANE_COUNT]          = rx_lockedtodata_sync;
      lock_word[LOCK_REF_LSB +: LANE_COUNT]           = rx_lockedtoref_sync;
   end

   always_comb begin
      rst_word             = '0;
      rst_word[RST_TX_BIT] = tx_reset_req;
      rst_word[RST_RX_BIT] = rx_reset_req;
   end

   assign loop_word = {{(MGMT_DATA_W-LANE_COUNT){1'b0}}, serial_loopback};

   always_comb begin
      pma_readdata = '0;
      if (pma_hit) begin
         case (mgmt_address.pma.csr_index)
            PMA_LOCK_STATUS: pma_readdata = lock_word;
            PMA_RESET_CTRL:  pma_readdata = rst_word;
            PMA_LOOPBACK:    pma_readdata = loop_word;
            default:         pma_readdata = '0;
         endcase
      end
   end

   // PCS traffic must leave the PMA controls alone
   a_pcs_write_no_effect: assert property (@(posedge mgmt_clk) disable iff (!rst_n)
      (mgmt_write && mgmt_address.pma.pcs_space)
      |=> $stable({tx_reset_req, rx_reset_req, serial_loopback}));

endmodule

// ==== verilog/ilk_lane_csr.sv ====
//####################
// PCS lane registers
// indirect lane select, one-hot lane enables and the
// status word of the selected lane
//####################
`timescale 1ns/1ns

module ilk_lane_csr
   import ilk_mgmt_pkg::*;
(
   input  logic                                   mgmt_clk,
   input  logic                                   rst_n,
   input  logic                                   mgmt_write,
   input  mgmt_addr_t                             mgmt_address,
   input  logic [MGMT_DATA_W-1:0]                 mgmt_writedata,
   input  logic [LANE_COUNT-1:0][LANE_STAT_W-1:0] rx_lane_status_sync,
   output logic [MGMT_DATA_W-1:0]                 pcs_readdata
);

   logic                   pcs_hit;     // PCS space, page 0
   logic                   sel_wr;
   logic [LANE_SEL_W-1:0]  lane_sel;
   logic [LANE_COUNT-1:0]  lane_en;
   logic [LANE_STAT_W-1:0] sel_stat;    // flags of the enabled lane
   logic [MGMT_DATA_W-1:0] stat_word;

   assign pcs_hit = mgmt_address.pcs.pcs_space && (mgmt_address.pcs.page == PCS_PAGE);
   assign sel_wr  = mgmt_write && pcs_hit && (mgmt_address.pcs.lane_reg == PCS_LANE_SEL);

   //####################
   // lane select
   //####################
   always_ff @(posedge mgmt_clk) begin
      if (!rst_n) begin
         lane_sel <= '0;
      end else if (sel_wr) begin
         lane_sel <= mgmt_writedata[LANE_SEL_W-1:0];
      end
   end

   // selects past the last lane match nothing
   always_comb begin
      lane_en = '0;
      for (int i = 0; i < LANE_COUNT; i++) begin
         lane_en[i] = (lane_sel == LANE_SEL_W'(i));
      end
   end

   //####################
   // status of the selected lane
   //####################
   always_comb begin
      sel_stat = '0;
      for (int i = 0; i < LANE_COUNT; i++) begin
         sel_stat |= rx_lane_status_sync[i] & {LANE_STAT_W{lane_en[i]}};
      end
   end

   always_comb begin
      stat_word                    = '0;
      stat_word[ST_ALIGN_VAL]      = sel_stat[0];
      stat_word[ST_FRAME_LOCK]     = sel_stat[1];
      stat_word[ST_FRAMING_ERR]    = sel_stat[2];
      stat_word[ST_CRC32_ERR]      = sel_stat[3];
      stat_word[ST_SCRAM_MISMATCH] = sel_stat[4];
      stat_word[ST_MISSING_SYNC]   = sel_stat[5];
   end

   always_comb begin
      pcs_readdata = '0;
      if (pcs_hit) begin
         case (mgmt_address.pcs.lane_reg)
            PCS_LANE_SEL:    pcs_readdata[LANE_SEL_W-1:0] = lane_sel;
            PCS_LANE_STATUS: pcs_readdata = stat_word;
            default:         pcs_readdata = '0;   // regs 2 and 3 unmapped
         endcase
      end
   end

   // at most one lane enabled, and exactly one for an in-range select
   a_lane_en_onehot: assert property (@(posedge mgmt_clk) disable iff (!rst_n)
      $onehot0(lane_en) && ((|lane_en) == (lane_sel < LANE_COUNT)));

endmodule

// ==== verilog/ilk_status_sync.sv ====
//####################
// Status synchronizers
// brings pll lock and per-lane rx lock/status into mgmt_clk
// through SYNC_DEPTH flops, all cleared on reset
//####################
`timescale 1ns/1ns

module ilk_status_sync
   import ilk_mgmt_pkg::*;
(
   input  logic                                   mgmt_clk,
   input  logic                                   rst_n,
   input  logic                                   pll_locked,
   input  logic [LANE_COUNT-1:0]                  rx_lockedtodata,
   input  logic [LANE_COUNT-1:0]                  rx_lockedtoref,
   input  logic [LANE_COUNT-1:0][LANE_STAT_W-1:0] rx_lane_status,
   output logic                                   pll_locked_sync,
   output logic [LANE_COUNT-1:0]                  rx_lockedtodata_sync,
   output logic [LANE_COUNT-1:0]                  rx_lockedtoref_sync,
   output logic [LANE_COUNT-1:0][LANE_STAT_W-1:0] rx_lane_status_sync
);

   logic [SYNC_DEPTH-1:0] pll_pipe;   // bit 0 is the first stage

   always_ff @(posedge mgmt_clk) begin
      if (!rst_n) pll_pipe <= '0;
      else        pll_pipe <= {pll_pipe[SYNC_DEPTH-2:0], pll_locked};
   end

   assign pll_locked_sync = pll_pipe[SYNC_DEPTH-1];

   // one chain per lane, carrying both lock bits and the status flags
   for (genvar i = 0; i < LANE_COUNT; i++) begin : g_lane
      logic [SYNC_DEPTH-1:0][LANE_STAT_W+1:0] lane_pipe;

      always_ff @(posedge mgmt_clk) begin
         if (!rst_n) begin
            lane_pipe <= '0;
         end else begin
            lane_pipe <= {lane_pipe[SYNC_DEPTH-2:0],
                          {rx_lane_status[i], rx_lockedtoref[i], rx_lockedtodata[i]}};
         end
      end

      assign {rx_lane_status_sync[i], rx_lockedtoref_sync[i], rx_lockedtodata_sync[i]} =
         lane_pipe[SYNC_DEPTH-1];
   end

endmodule

// ==== verilog/ilk_mgmt_pkg.sv ====
//####################
// Interlaken management package
// widths, lane count, register map, status bit positions
// and the two views of the management word address
//####################
package ilk_mgmt_pkg;

   //####################
   // bus and lane sizes
   //####################
   localparam int LANE_COUNT  = 4;
   localparam int LANE_SEL_W  = $clog2(LANE_COUNT) + 1;  // spare bit reaches unused lanes
   localparam int MGMT_ADDR_W = 8;
   localparam int MGMT_DATA_W = 32;
   localparam int LANE_STAT_W = 6;   // rx status bits per lane
   localparam int SYNC_DEPTH  = 2;   // flops per synchronizer

   // lane status word, bit positions of the six rx flags
   localparam int ST_ALIGN_VAL      = 24;
   localparam int ST_FRAME_LOCK     = 25;
   localparam int ST_FRAMING_ERR    = 26;
   localparam int ST_CRC32_ERR      = 27;
   localparam int ST_SCRAM_MISMATCH = 28;
   localparam int ST_MISSING_SYNC   = 29;

   //####################
   // PMA space (address bit 7 low)
   //####################
   localparam logic [MGMT_ADDR_W-2:0] PMA_LOCK_STATUS = 7'd0;
   localparam logic [MGMT_ADDR_W-2:0] PMA_RESET_CTRL  = 7'd1;
   localparam logic [MGMT_ADDR_W-2:0] PMA_LOOPBACK    = 7'd2;

   // lock status word layout
   localparam int LOCK_PLL_BIT  = 0;
   localparam int LOCK_DATA_LSB = 4;   // rx locked-to-data, one bit per lane
   localparam int LOCK_REF_LSB  = 8;   // rx locked-to-ref, one bit per lane

   // reset control word
   localparam int RST_TX_BIT = 0;
   localparam int RST_RX_BIT = 1;

   //####################
   // PCS space (address bit 7 high)
   //####################
   localparam logic [4:0] PCS_PAGE        = 5'b00000;
   localparam logic [1:0] PCS_LANE_SEL    = 2'd0;
   localparam logic [1:0] PCS_LANE_STATUS = 2'd1;

   // one address word, decoded as a flat PMA index or as PCS page/register
   typedef union packed {
      struct packed {
         logic                   pcs_space;
         logic [MGMT_ADDR_W-2:0] csr_index;
      } pma;
      struct packed {
         logic       pcs_space;
         logic [4:0] page;
         logic [1:0] lane_reg;
      } pcs;
   } mgmt_addr_t;

endpackage
